// ==== all.f ====
common/core_pkg.sv
common/imem_if.sv
fetch/core_s1_control.sv
fetch/core_s1.sv
source/instr_mem.sv
source/core_s2_decode.sv
source/core_frontend.sv
sim/tb_core_frontend.sv

// ==== common/core_pkg.sv ====
/*
 * Front end shared definitions
 * Word and instruction format types, opcodes, stage-to-stage structs,
 * fetch FSM states and instruction memory sizing
 */

package core_pkg;

    typedef logic [31:0] word_t;

    // Fetch starts here out of reset
    localparam word_t RESET_PC = 32'h0000_0000;

    // Instruction memory geometry, word index is pc[9:2]
    localparam int IMEM_DEPTH = 256;
    localparam int IMEM_AW    = 8;
    // Cycles between req seen and ack raised
    localparam int IMEM_WAIT  = 2;
    localparam int IMEM_CNT_W = $clog2(IMEM_WAIT + 1);

    // Opcodes recognized by decode
    localparam logic [6:0] OP_JAL   = 7'b1101111;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_OPIMM = 7'b0010011;
    localparam logic [6:0] OP_OP    = 7'b0110011;
    // custom-0 space, used as program exit
    localparam logic [6:0] OP_EXIT  = 7'b0001011;

    // Format views, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_s;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_s;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_s;

    // J immediate bits are scattered across the upper word
    typedef struct packed {
        logic        imm_20;
        logic [9:0]  imm_10_1;
        logic        imm_11;
        logic [7:0]  imm_19_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } j_fmt_s;

    // Same 32 bits, field placement depends on opcode
    typedef union packed {
        r_fmt_s r_fmt;
        i_fmt_s i_fmt;
        u_fmt_s u_fmt;
        j_fmt_s j_fmt;
    } instr_u;

    typedef enum logic [2:0] {
        KIND_OP,
        KIND_OPIMM,
        KIND_LUI,
        KIND_JAL,
        KIND_EXIT,
        KIND_ILLEGAL
    } instr_kind_e;

    // Fetch FSM states
    typedef enum logic [2:0] {
        S1_IDLE,
        S1_REQUEST,
        S1_RELEASE,
        S1_WAIT_BUSY,
        S1_HALT
    } s1_state_e;

    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_u instr;
    } s1_to_s2_s;

    typedef struct packed {
        logic  redirect;
        word_t redirect_pc;
        logic  halt_req;
    } s2_to_s1_s;

endpackage : core_pkg

// ==== common/imem_if.sv ====
/*
 * Instruction fetch link
 * Four-phase req/ack handshake between fetch and instruction memory
 */

`timescale 1ns/1ps

interface imem_if;
    import core_pkg::*;

    // Request side, addr held stable while req is high
    logic  req;
    word_t addr;

    // Response side, instr valid while ack is high
    logic  ack;
    word_t instr;

    modport fetch (
        output req,
        output addr,
        input  ack,
        input  instr
    );

    modport mem (
        input  req,
        input  addr,
        output ack,
        output instr
    );

endinterface : imem_if

// ==== fetch/core_s1.sv ====
/*
 * Fetch stage (s1)
 * Holds the PC, runs the four-phase request to instruction memory
 * and registers the returned word with its PC toward decode
 */

`timescale 1ns/1ps

module core_s1 (
    input  logic                  clk,
    input  logic                  rst_n,

    // Decode holds a stalled instruction
    input  logic                  s2_busy,

    // External trap redirect
    input  logic                  trap_occurred,
    input  core_pkg::word_t       trap_target_addr,

    // Decode side
    output core_pkg::s1_to_s2_s   s1_to_s2,
    input  core_pkg::s2_to_s1_s   s2_to_s1,

    output logic                  halted,

    imem_if.fetch                 bus
);
    import core_pkg::*;

    logic   flush;
    logic   start_req;
    logic   drop_req;
    logic   capture;
    logic   stall;

    word_t  pc_ff;
    word_t  next_pc;
    word_t  addr_ff;
    logic   req_ff;

    logic   s1_valid_ff;
    word_t  s1_pc_ff;
    instr_u s1_instr_ff;

    // Trap or JAL both kill the current path
    assign flush = trap_occurred | s2_to_s1.redirect;

    // Trap wins over a JAL redirect
    always_comb begin
        if (trap_occurred) begin
            next_pc = trap_target_addr;
        end else if (s2_to_s1.redirect) begin
            next_pc = s2_to_s1.redirect_pc;
        end else if (start_req) begin
            next_pc = pc_ff + 32'd4;
        end else begin
            next_pc = pc_ff;
        end
    end

    // pc_ff is the next address to request, frozen once halted
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            pc_ff <= RESET_PC;
        end else if (!halted) begin
            pc_ff <= next_pc;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            req_ff <= 1'b0;
        end else if (start_req) begin
            req_ff <= 1'b1;
        end else if (drop_req) begin
            req_ff <= 1'b0;
        end
    end

    // Latch the request address so a redirect cannot move it mid-handshake
    always_ff @(posedge clk) begin
        if (start_req) begin
            addr_ff <= pc_ff;
        end
    end

    assign bus.req  = req_ff;
    assign bus.addr = addr_ff;

    // Output register toward decode
    // Consumed whenever decode is not busy, dropped on flush
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            s1_valid_ff <= 1'b0;
        end else if (flush) begin
            s1_valid_ff <= 1'b0;
        end else if (capture) begin
            s1_valid_ff <= 1'b1;
        end else if (!stall) begin
            s1_valid_ff <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            s1_pc_ff    <= addr_ff;
            s1_instr_ff <= bus.instr;
        end
    end

    assign s1_to_s2.valid = s1_valid_ff;
    assign s1_to_s2.pc    = s1_pc_ff;
    assign s1_to_s2.instr = s1_instr_ff;

    core_s1_control u_control (
        .clk       (clk),
        .rst_n     (rst_n),
        .ack       (bus.ack),
        .s2_busy   (s2_busy),
        .flush     (flush),
        .halt_req  (s2_to_s1.halt_req),
        .start_req (start_req),
        .drop_req  (drop_req),
        .capture   (capture),
        .stall     (stall),
        .halted    (halted)
    );

    // New request only after memory has released the previous ack
    a_req_after_ack_low: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(bus.req) |-> !bus.ack
    );

endmodule : core_s1

// ==== fetch/core_s1_control.sv ====
/*
 * Fetch stage FSM
 * Sequences the four req/ack phases, holds off new requests while
 * decode is busy, discards wrong-path words and freezes on halt
 */

`timescale 1ns/1ps

module core_s1_control (
    input  logic clk,
    input  logic rst_n,
    input  logic ack,
    input  logic s2_busy,
    input  logic flush,
    input  logic halt_req,
    output logic start_req,
    output logic drop_req,
    output logic capture,
    output logic stall,
    output logic halted
);
    import core_pkg::*;

    s1_state_e state_ff;
    s1_state_e state_nx;
    // Word in flight belongs to a flushed path
    logic      discard_ff;

    always_comb begin
        state_nx  = state_ff;
        start_req = 1'b0;
        drop_req  = 1'b0;
        capture   = 1'b0;
        case (state_ff)
            S1_IDLE, S1_WAIT_BUSY: begin
                if (halt_req) begin
                    state_nx = S1_HALT;
                end else if (!s2_busy && !flush) begin
                    start_req = 1'b1;
                    state_nx  = S1_REQUEST;
                end
            end
            S1_REQUEST: begin
                // Take the word in the ack cycle, then release req
                if (ack) begin
                    drop_req = 1'b1;
                    capture  = !discard_ff && !flush && !halt_req;
                    state_nx = S1_RELEASE;
                end
            end
            S1_RELEASE: begin
                // Wait for memory to drop ack
                if (!ack) begin
                    if (halt_req) begin
                        state_nx = S1_HALT;
                    end else if (s2_busy || flush) begin
                        state_nx = S1_WAIT_BUSY;
                    end else begin
                        start_req = 1'b1;
                        state_nx  = S1_REQUEST;
                    end
                end
            end
            default: begin
                state_nx = S1_HALT;
            end
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state_ff   <= S1_IDLE;
            discard_ff <= 1'b0;
        end else begin
            state_ff <= state_nx;
            if (state_ff == S1_REQUEST) begin
                if (ack) begin
                    discard_ff <= 1'b0;
                end else if (flush || halt_req) begin
                    discard_ff <= 1'b1;
                end
            end
        end
    end

    assign halted = (state_ff == S1_HALT);
    // Output register holds while decode is busy or after halt
    assign stall  = s2_busy | halted;

endmodule : core_s1_control

// ==== run.sh ====
#!/bin/sh
# Build the front end testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f all.f --top-module tb_core_frontend \
    -Mdir obj_dir -o tb_core_frontend \
    && ./obj_dir/tb_core_frontend > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run did not complete"; exit 1; }

cat sim.log
grep -qx "PASS: all tests" sim.log && exit 0 || exit 1

// ==== sim/tb_core_frontend.sv ====
/*
 * Front end testbench
 * Loads programs into instruction memory, runs fetch and decode and
 * checks the presented stream against a reference decoder
 */

`timescale 1ns/1ps

module tb_core_frontend;
    import core_pkg::*;

    localparam int NUM_TESTS = 6;
    localparam int RUN_LIMIT = 300;

    logic                clk;
    logic                rst_n;
    logic                out_stall;
    logic                trap_occurred;
    word_t               trap_target_addr;
    logic                prog_we;
    logic [IMEM_AW-1:0]  prog_addr;
    word_t               prog_data;
    logic                out_valid;
    word_t               out_pc;
    word_t               out_instr;
    instr_kind_e         out_kind;
    logic [4:0]          out_rd;
    word_t               out_imm;
    logic                halted;

    int          value_errs;
    int          other_errs;
    logic [31:0] lfsr_q;

    // Program image, mirrored into the DUT memory
    word_t       image [IMEM_DEPTH];

    // Presented stream and reference stream
    word_t       got_pc[$];
    word_t       got_instr[$];
    instr_kind_e got_kind[$];
    logic [4:0]  got_rd[$];
    word_t       got_imm[$];
    word_t       exp_pc[$];
    word_t       exp_instr[$];
    instr_kind_e exp_kind[$];
    logic [4:0]  exp_rd[$];
    word_t       exp_imm[$];

    core_frontend dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .out_stall        (out_stall),
        .trap_occurred    (trap_occurred),
        .trap_target_addr (trap_target_addr),
        .prog_we          (prog_we),
        .prog_addr        (prog_addr),
        .prog_data        (prog_data),
        .out_valid        (out_valid),
        .out_pc           (out_pc),
        .out_instr        (out_instr),
        .out_kind         (out_kind),
        .out_rd           (out_rd),
        .out_imm          (out_imm),
        .halted           (halted)
    );

    always #4 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic word_t rand_word(input logic [6:0] op);
        logic [31:0] r;
        r = rand_bits(25);
        return {r[24:0], op};
    endfunction

    function automatic word_t rand_alu_word();
        logic [31:0] b;
        b = rand_bits(1);
        return rand_word(b[0] ? OP_OPIMM : OP_OP);
    endfunction

    // Instruction encoders
    function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd,
                                    input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OP_LUI};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // OP word that carries all 8 index bits in funct3 and rd
    function automatic word_t fill_word(input int idx);
        logic [7:0] a;
        a = idx[7:0];
        return {17'h0, a[7:5], a[4:0], OP_OP};
    endfunction

    // Reference decoder, straight from the raw bit positions
    function automatic instr_kind_e ref_kind(input word_t w);
        case (w[6:0])
            OP_OP:    return KIND_OP;
            OP_OPIMM: return KIND_OPIMM;
            OP_LUI:   return KIND_LUI;
            OP_JAL:   return KIND_JAL;
            OP_EXIT:  return KIND_EXIT;
            default:  return KIND_ILLEGAL;
        endcase
    endfunction

    function automatic logic [4:0] ref_rd(input word_t w);
        return (ref_kind(w) == KIND_ILLEGAL) ? 5'd0 : w[11:7];
    endfunction

    function automatic word_t ref_imm(input word_t w);
        case (ref_kind(w))
            KIND_OPIMM, KIND_EXIT: return {{20{w[31]}}, w[31:20]};
            KIND_LUI:              return {w[31:12], 12'h000};
            KIND_JAL:              return {{11{w[31]}}, w[31], w[19:12], w[20],
                                           w[30:21], 1'b0};
            default:               return 32'h0;
        endcase
    endfunction

    // Walk the image from start_pc, following JAL, up to EXIT
    task automatic build_expected(input word_t start_pc);
        word_t       pc;
        word_t       w;
        instr_kind_e k;
        int          n;
        exp_pc.delete();
        exp_instr.delete();
        exp_kind.delete();
        exp_rd.delete();
        exp_imm.delete();
        pc = start_pc;
        for (n = 0; n < 64; n++) begin
            w = image[pc[9:2]];
            k = ref_kind(w);
            exp_pc.push_back(pc);
            exp_instr.push_back(w);
            exp_kind.push_back(k);
            exp_rd.push_back(ref_rd(w));
            exp_imm.push_back(ref_imm(w));
            if (k == KIND_EXIT) begin
                break;
            end
            pc = (k == KIND_JAL) ? pc + ref_imm(w) : pc + 32'd4;
        end
    endtask

    task automatic check_word(input string sig, input int idx, input word_t got,
                              input word_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %s [%0d] got %h exp %h", sig, idx, got, exp);
        end
    endtask

    task automatic check_kind(input string sig, input int idx, input instr_kind_e got,
                              input instr_kind_e exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %s [%0d] got %h exp %h", sig, idx, got, exp);
        end
    endtask

    task automatic check_rd(input string sig, input int idx, input logic [4:0] got,
                            input logic [4:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %s [%0d] got %h exp %h", sig, idx, got, exp);
        end
    endtask

    task automatic check_flag(input string sig, input int idx, input logic got,
                              input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %s [%0d] got %h exp %h", sig, idx, got, exp);
        end
    endtask

    task automatic clear_image();
        int i;
        for (i = 0; i < IMEM_DEPTH; i++) begin
            image[i] = fill_word(i);
        end
    endtask

    // Copy the first count image words through the program port
    task automatic load_image(input int count);
        int i;
        for (i = 0; i < count; i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = IMEM_AW'(i);
            prog_data = image[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic pulse_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // Record every transfer until EXIT goes out
    // trap_after >= 0 fires one trap once that many words have passed
    task automatic run_stream(input bit stall_on, input int trap_after,
                              input word_t trap_pc);
        int          cycles;
        bit          done;
        bit          pulsed;
        logic [31:0] r;
        got_pc.delete();
        got_instr.delete();
        got_kind.delete();
        got_rd.delete();
        got_imm.delete();
        cycles = 0;
        done   = 1'b0;
        pulsed = 1'b0;
        while (!done && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
            trap_occurred = 1'b0;
            if (trap_after >= 0 && !pulsed && got_pc.size() > trap_after) begin
                trap_occurred    = 1'b1;
                trap_target_addr = trap_pc;
                pulsed           = 1'b1;
            end
            r         = stall_on ? rand_bits(1) : 32'h0;
            out_stall = r[0];
            // Word leaves decode at the coming edge
            if (out_valid && !out_stall) begin
                got_pc.push_back(out_pc);
                got_instr.push_back(out_instr);
                got_kind.push_back(out_kind);
                got_rd.push_back(out_rd);
                got_imm.push_back(out_imm);
                done = (out_kind == KIND_EXIT);
            end
        end
        trap_occurred = 1'b0;
        out_stall     = 1'b0;
        if (!done) begin
            other_errs++;
            $display("no EXIT was presented within %0d cycles", RUN_LIMIT);
        end
    endtask

    task automatic compare_stream(input int offset);
        int n;
        int i;
        n = got_pc.size() - offset;
        if (n != exp_pc.size()) begin
            other_errs++;
            $display("stream holds %0d words from entry %0d, reference holds %0d",
                     n, offset, exp_pc.size());
        end
        for (i = 0; i < n && i < exp_pc.size(); i++) begin
            check_word("out_pc", i, got_pc[offset + i], exp_pc[i]);
            check_word("out_instr", i, got_instr[offset + i], exp_instr[i]);
            check_kind("out_kind", i, got_kind[offset + i], exp_kind[i]);
            check_rd("out_rd", i, got_rd[offset + i], exp_rd[i]);
            check_word("out_imm", i, got_imm[offset + i], exp_imm[i]);
        end
    endtask

    task automatic test_straight_line();
        int i;
        $display("test: straight line");
        clear_image();
        for (i = 0; i < 12; i++) begin
            image[i] = rand_alu_word();
        end
        image[12] = enc_i(12'h123, 5'd0, 3'd0, 5'd1, OP_EXIT);
        load_image(16);
        pulse_reset();
        build_expected(RESET_PC);
        run_stream(1'b0, -1, '0);
        compare_stream(0);
    endtask

    task automatic test_jal_skip();
        int i;
        int j;
        $display("test: jal forward");
        clear_image();
        for (i = 0; i < 8; i++) begin
            image[i] = rand_alu_word();
        end
        // Jump from 0x08 to 0x18, words 3 to 5 are skipped
        image[2] = enc_j(21'h10, 5'd1);
        image[8] = enc_i(12'h000, 5'd0, 3'd0, 5'd0, OP_EXIT);
        load_image(12);
        pulse_reset();
        build_expected(RESET_PC);
        run_stream(1'b0, -1, '0);
        compare_stream(0);
        j = -1;
        for (i = 0; i < got_kind.size(); i++) begin
            if (j < 0 && got_kind[i] == KIND_JAL) begin
                j = i;
            end
        end
        if (j < 0 || j + 1 >= got_pc.size()) begin
            other_errs++;
            $display("JAL or its target is missing from the stream");
        end else begin
            check_word("out_imm", j, got_imm[j], 32'h0000_0010);
            check_word("out_pc", j + 1, got_pc[j + 1], 32'h0000_0018);
        end
    endtask

    task automatic test_lui_neg_imm();
        $display("test: lui and negative immediates");
        clear_image();
        image[0] = enc_u(20'hfedcb, 5'd5);
        image[1] = enc_i(12'h800, 5'd5, 3'd0, 5'd6, OP_OPIMM);
        image[2] = enc_i(12'hfff, 5'd6, 3'd4, 5'd7, OP_OPIMM);
        image[3] = enc_u(20'h00001, 5'd8);
        image[4] = enc_i(12'h7ff, 5'd8, 3'd0, 5'd9, OP_OPIMM);
        // Load opcode, not decoded here
        image[5] = 32'h0000_2003;
        image[6] = enc_i(12'hf00, 5'd0, 3'd0, 5'd0, OP_EXIT);
        load_image(10);
        pulse_reset();
        build_expected(RESET_PC);
        run_stream(1'b0, -1, '0);
        compare_stream(0);
        if (got_imm.size() < 7) begin
            other_errs++;
            $display("fewer than 7 words presented in the immediate test");
        end else begin
            check_word("out_imm", 0, got_imm[0], 32'hfedc_b000);
            check_word("out_imm", 1, got_imm[1], 32'hffff_f800);
            check_word("out_imm", 2, got_imm[2], 32'hffff_ffff);
            check_word("out_imm", 3, got_imm[3], 32'h0000_1000);
            check_kind("out_kind", 5, got_kind[5], KIND_ILLEGAL);
            check_word("out_imm", 6, got_imm[6], 32'hffff_ff00);
        end
    endtask

    task automatic test_random_stall();
        int i;
        $display("test: random stall");
        clear_image();
        for (i = 0; i < 14; i++) begin
            image[i] = rand_alu_word();
        end
        image[14] = enc_i(12'h0aa, 5'd0, 3'd0, 5'd3, OP_EXIT);
        load_image(18);
        build_expected(RESET_PC);
        // Same program, first free running then under random stall
        pulse_reset();
        run_stream(1'b0, -1, '0);
        compare_stream(0);
        pulse_reset();
        run_stream(1'b1, -1, '0);
        compare_stream(0);
    endtask

    task automatic test_trap_redirect();
        int i;
        int k;
        $display("test: trap redirect");
        clear_image();
        // Fall-through exit, so the target is reached only through the trap
        image[8] = enc_i(12'h000, 5'd0, 3'd0, 5'd0, OP_EXIT);
        for (i = 32; i < 35; i++) begin
            image[i] = rand_word(OP_OPIMM);
        end
        image[35] = enc_i(12'h055, 5'd0, 3'd0, 5'd2, OP_EXIT);
        load_image(40);
        pulse_reset();
        build_expected(32'h0000_0080);
        run_stream(1'b0, 1, 32'h0000_0080);
        k = -1;
        for (i = 0; i < got_pc.size(); i++) begin
            if (k < 0 && got_pc[i] == 32'h0000_0080) begin
                k = i;
            end
        end
        if (k < 0) begin
            other_errs++;
            $display("trap target 00000080 never appeared in the stream");
        end else begin
            compare_stream(k);
        end
    endtask

    task automatic test_halt_quiet();
        int  i;
        bit  ok;
        $display("test: halt after exit");
        clear_image();
        image[0] = rand_alu_word();
        image[1] = rand_alu_word();
        image[2] = enc_i(12'h000, 5'd0, 3'd0, 5'd0, OP_EXIT);
        load_image(6);
        pulse_reset();
        build_expected(RESET_PC);
        run_stream(1'b0, -1, '0);
        compare_stream(0);
        // Fetch may still be waiting on an ack
        for (i = 0; i < 20 && !halted; i++) begin
            @(negedge clk);
        end
        if (!halted) begin
            other_errs++;
            $display("halted did not rise after EXIT was presented");
        end
        ok = 1'b1;
        for (i = 0; i < 50 && ok; i++) begin
            @(negedge clk);
            if (out_valid !== 1'b0 || halted !== 1'b1) begin
                check_flag("out_valid", i, out_valid, 1'b0);
                check_flag("halted", i, halted, 1'b1);
                ok = 1'b0;
            end
        end
    endtask

    // Watchdog sized from the test count
    initial begin
        repeat (400 * NUM_TESTS) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish",
                 400 * NUM_TESTS);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        clk              = 1'b0;
        rst_n            = 1'b0;
        out_stall        = 1'b0;
        trap_occurred    = 1'b0;
        trap_target_addr = '0;
        prog_we          = 1'b0;
        prog_addr        = '0;
        prog_data        = '0;
        value_errs       = 0;
        other_errs       = 0;
        lfsr_q           = 32'hc302;

        test_straight_line();
        test_jal_skip();
        test_lui_neg_imm();
        test_random_stall();
        test_trap_redirect();
        test_halt_quiet();

        $display("errors: %0d value mismatches, %0d other failures",
                 value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_core_frontend

// ==== source/core_frontend.sv ====
/*
 * Pipeline front end top
 * Instruction memory, fetch and decode joined behind plain ports
 */

`timescale 1ns/1ps

module core_frontend (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          out_stall,
    input  logic                          trap_occurred,
    input  core_pkg::word_t               trap_target_addr,
    input  logic                          prog_we,
    input  logic [core_pkg::IMEM_AW-1:0]  prog_addr,
    input  core_pkg::word_t               prog_data,
    output logic                          out_valid,
    output core_pkg::word_t               out_pc,
    output core_pkg::word_t               out_instr,
    output core_pkg::instr_kind_e         out_kind,
    output logic [4:0]                    out_rd,
    output core_pkg::word_t               out_imm,
    output logic                          halted
);
    import core_pkg::*;

    s1_to_s2_s s1_to_s2;
    s2_to_s1_s s2_to_s1;
    logic      s2_busy;

    imem_if imem_bus ();

    instr_mem u_imem (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .bus       (imem_bus.mem)
    );

    core_s1 u_s1 (
        .clk              (clk),
        .rst_n            (rst_n),
        .s2_busy          (s2_busy),
        .trap_occurred    (trap_occurred),
        .trap_target_addr (trap_target_addr),
        .s1_to_s2         (s1_to_s2),
        .s2_to_s1         (s2_to_s1),
        .halted           (halted),
        .bus              (imem_bus.fetch)
    );

    core_s2_decode u_s2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_stall (out_stall),
        .s1_to_s2  (s1_to_s2),
        .s2_to_s1  (s2_to_s1),
        .s2_busy   (s2_busy),
        .out_valid (out_valid),
        .out_pc    (out_pc),
        .out_instr (out_instr),
        .out_kind  (out_kind),
        .out_rd    (out_rd),
        .out_imm   (out_imm)
    );

endmodule : core_frontend

// ==== source/core_s2_decode.sv ====
/*
 * Decode stage (s2)
 * Classifies the fetched word, extracts rd and the immediate,
 * redirects fetch on JAL, requests halt on EXIT, holds under stall
 */

`timescale 1ns/1ps

module core_s2_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    out_stall,

    input  core_pkg::s1_to_s2_s     s1_to_s2,
    output core_pkg::s2_to_s1_s     s2_to_s1,
    output logic                    s2_busy,

    output logic                    out_valid,
    output core_pkg::word_t         out_pc,
    output core_pkg::word_t         out_instr,
    output core_pkg::instr_kind_e   out_kind,
    output logic [4:0]              out_rd,
    output core_pkg::word_t         out_imm
);
    import core_pkg::*;

    instr_u      in_instr;
    instr_kind_e kind;
    logic [4:0]  rd;
    word_t       imm;
    logic        accept;

    logic        redirect_ff;
    word_t       redirect_pc_ff;
    logic        exit_seen_ff;

    assign in_instr = s1_to_s2.instr;

    // Pick the format view from the opcode
    always_comb begin
        kind = KIND_ILLEGAL;
        rd   = '0;
        imm  = '0;
        case (in_instr.r_fmt.opcode)
            OP_OP: begin
                kind = KIND_OP;
                rd   = in_instr.r_fmt.rd;
            end
            OP_OPIMM, OP_EXIT: begin
                kind = (in_instr.i_fmt.opcode == OP_EXIT) ? KIND_EXIT : KIND_OPIMM;
                rd   = in_instr.i_fmt.rd;
                imm  = {{20{in_instr.i_fmt.imm[11]}}, in_instr.i_fmt.imm};
            end
            OP_LUI: begin
                kind = KIND_LUI;
                rd   = in_instr.u_fmt.rd;
                imm  = {in_instr.u_fmt.imm, 12'h000};
            end
            OP_JAL: begin
                kind = KIND_JAL;
                rd   = in_instr.j_fmt.rd;
                imm  = {{11{in_instr.j_fmt.imm_20}}, in_instr.j_fmt.imm_20,
                        in_instr.j_fmt.imm_19_12, in_instr.j_fmt.imm_11,
                        in_instr.j_fmt.imm_10_1, 1'b0};
            end
            default: begin
                kind = KIND_ILLEGAL;
            end
        endcase
    end

    assign s2_busy = out_valid & out_stall;
    // Nothing taken past EXIT or in the cycle fetch is being redirected
    assign accept  = s1_to_s2.valid && !s2_busy && !redirect_ff && !exit_seen_ff;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            out_valid    <= 1'b0;
            redirect_ff  <= 1'b0;
            exit_seen_ff <= 1'b0;
        end else begin
            redirect_ff <= accept && (kind == KIND_JAL);
            if (accept && (kind == KIND_EXIT)) begin
                exit_seen_ff <= 1'b1;
            end
            if (!s2_busy) begin
                out_valid <= accept;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_pc         <= s1_to_s2.pc;
            out_instr      <= s1_to_s2.instr;
            out_kind       <= kind;
            out_rd         <= rd;
            out_imm        <= imm;
            redirect_pc_ff <= s1_to_s2.pc + imm;
        end
    end

    assign s2_to_s1.redirect    = redirect_ff;
    assign s2_to_s1.redirect_pc = redirect_pc_ff;
    assign s2_to_s1.halt_req    = exit_seen_ff;

    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && out_stall |=> out_valid && $stable(out_pc) &&
            $stable(out_instr) && $stable(out_kind) && $stable(out_rd) &&
            $stable(out_imm)
    );

endmodule : core_s2_decode

// ==== source/instr_mem.sv ====
/*
 * Instruction memory
 * Word array loaded through a program port, read through a
 * four-phase responder that waits a fixed count before ack
 */

`timescale 1ns/1ps

module instr_mem (
    input  logic                          clk,
    input  logic                          rst_n,

    // Program load port
    input  logic                          prog_we,
    input  logic [core_pkg::IMEM_AW-1:0]  prog_addr,
    input  core_pkg::word_t               prog_data,

    imem_if.mem                           bus
);
    import core_pkg::*;

    word_t                 mem_q [IMEM_DEPTH];
    logic [IMEM_AW-1:0]    rd_idx;
    logic [IMEM_CNT_W-1:0] wait_cnt;
    logic                  ack_ff;
    logic                  ack_rise;
    word_t                 instr_ff;

    // Byte address to word index
    assign rd_idx = bus.addr[IMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem_q[prog_addr] <= prog_data;
        end
    end

    // Last wait cycle of a pending request
    assign ack_rise = bus.req && !ack_ff &&
                      (wait_cnt == IMEM_CNT_W'(IMEM_WAIT - 1));

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            ack_ff   <= 1'b0;
            wait_cnt <= '0;
        end else if (ack_rise) begin
            ack_ff   <= 1'b1;
            wait_cnt <= '0;
        end else if (bus.req && !ack_ff) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else if (ack_ff && !bus.req) begin
            // Requester released, close the handshake
            ack_ff <= 1'b0;
        end
    end

    // Read data held for as long as ack stays high
    always_ff @(posedge clk) begin
        if (ack_rise) begin
            instr_ff <= mem_q[rd_idx];
        end
    end

    assign bus.ack   = ack_ff;
    assign bus.instr = instr_ff;

    a_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        bus.req |=> !bus.req || $stable(bus.addr)
    );

endmodule : instr_mem
